// ==== logic/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Datapath and bus widths
`define RV_XLEN     32
`define RV_REG_AW   5
`define RV_WB_AW    32
`define RV_RESET_PC 32'h0000_0000

// Instruction field positions
`define RV_OPC_MSB   6
`define RV_OPC_LSB   0
`define RV_RD_MSB    11
`define RV_RD_LSB    7
`define RV_F3_MSB    14
`define RV_F3_LSB    12
`define RV_RS1_MSB   19
`define RV_RS1_LSB   15
`define RV_IMM_I_LSB 20
`define RV_IMM_U_LSB 12
`define RV_EBREAK    32'h0010_0073

`endif

// ==== logic/rv_core_pkg.sv ====
`include "rv_core_consts.svh"

package rv_core_pkg;

    // ########################################################################
    // Encodings
    // ########################################################################

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_SYSTEM = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        CMD_NOP  = 4'd0,
        CMD_ADD  = 4'd1,
        CMD_EQU  = 4'd2,   // pass src1
        CMD_HALT = 4'd3
    } rv_exu_cmd_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_I    = 2'd1,
        IMM_U    = 2'd2
    } rv_imm_fmt_e;

    // ########################################################################
    // Records
    // ########################################################################

    typedef struct packed {
        rv_exu_cmd_e             cmd;
        logic [`RV_XLEN-1:0]     src1;
        logic [`RV_XLEN-1:0]     src2;
        logic [`RV_REG_AW-1:0]   rd;
    } rv_decode_t;

    // One entry per retired instruction
    typedef struct packed {
        logic [`RV_XLEN-1:0]     pc;
        logic [`RV_XLEN-1:0]     inst;
        logic [`RV_REG_AW-1:0]   rd;
        logic [`RV_XLEN-1:0]     data;
    } rv_retire_t;

endpackage

// ==== logic/rv_fetch.sv ====
`include "rv_core_consts.svh"

module rv_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   halted,
    input  logic                   retire_valid,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic [`RV_WB_AW-1:0]   wb_adr,
    input  logic [`RV_XLEN-1:0]    wb_dat_i,
    input  logic                   wb_ack,
    output logic [`RV_XLEN-1:0]    inst,
    output logic [`RV_XLEN-1:0]    pc,
    output logic                   inst_valid
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        EXEC,
        STOP
    } fetch_state_e;

    fetch_state_e state;

    // Request held for the whole REQ state at the PC
    assign wb_cyc = (state == REQ);
    assign wb_stb = (state == REQ);
    assign wb_adr = pc[`RV_WB_AW-1:0];

    // ########################################################################
    // Fetch sequencing
    // ########################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            pc         <= `RV_RESET_PC;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                IDLE: begin
                    state <= REQ;
                end
                REQ: begin
                    if (wb_ack) begin
                        inst_valid <= 1'b1;
                        state      <= EXEC;
                    end
                end
                EXEC: begin
                    // Wait for retirement before the next request
                    if (retire_valid) begin
                        pc    <= pc + `RV_XLEN'(4);
                        state <= halted ? STOP : REQ;
                    end
                end
                STOP: begin
                    state <= STOP;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Instruction word captured on ack
    always_ff @(posedge clk) begin
        if (state == REQ && wb_ack) begin
            inst <= wb_dat_i;
        end
    end

endmodule

// ==== logic/rv_decode.sv ====
`include "rv_core_consts.svh"

module rv_decode (
    input  logic [`RV_XLEN-1:0]    inst,
    input  logic [`RV_XLEN-1:0]    pc,
    input  logic                   inst_valid,
    input  logic [`RV_XLEN-1:0]    rdata1,
    output logic [`RV_REG_AW-1:0]  raddr1,
    output logic [`RV_REG_AW-1:0]  raddr2,
    output rv_core_pkg::rv_decode_t dec
);

    rv_core_pkg::rv_opcode_e  opcode;
    rv_core_pkg::rv_imm_fmt_e imm_fmt;
    logic [2:0]               funct3;
    logic [`RV_XLEN-1:0]      imm;
    logic                     rs1_used;
    logic                     rd_used;

    assign opcode = rv_core_pkg::rv_opcode_e'(inst[`RV_OPC_MSB:`RV_OPC_LSB]);
    assign funct3 = inst[`RV_F3_MSB:`RV_F3_LSB];

    // ########################################################################
    // Immediate
    // ########################################################################

    always_comb begin
        case (opcode)
            rv_core_pkg::OP_IMM:   imm_fmt = (funct3 == 3'b000) ? rv_core_pkg::IMM_I
                                                                : rv_core_pkg::IMM_NONE;
            rv_core_pkg::OP_LUI:   imm_fmt = rv_core_pkg::IMM_U;
            rv_core_pkg::OP_AUIPC: imm_fmt = rv_core_pkg::IMM_U;
            default:               imm_fmt = rv_core_pkg::IMM_NONE;
        endcase
    end

    always_comb begin
        case (imm_fmt)
            rv_core_pkg::IMM_I:
                imm = {{(`RV_XLEN-12){inst[`RV_XLEN-1]}}, inst[`RV_XLEN-1:`RV_IMM_I_LSB]};
            rv_core_pkg::IMM_U:
                imm = {inst[`RV_XLEN-1:`RV_IMM_U_LSB], {`RV_IMM_U_LSB{1'b0}}};
            default:
                imm = '0;
        endcase
    end

    // ########################################################################
    // Command and operands
    // ########################################################################

    always_comb begin
        dec.cmd  = rv_core_pkg::CMD_NOP;
        dec.src1 = '0;
        dec.src2 = '0;
        rs1_used = 1'b0;
        rd_used  = 1'b0;
        case (opcode)
            rv_core_pkg::OP_IMM: begin
                // Other funct3 values fall through as nop
                if (funct3 == 3'b000) begin
                    dec.cmd  = rv_core_pkg::CMD_ADD;
                    dec.src1 = imm;
                    dec.src2 = rdata1;
                    rs1_used = 1'b1;
                    rd_used  = 1'b1;
                end
            end
            rv_core_pkg::OP_LUI: begin
                dec.cmd  = rv_core_pkg::CMD_EQU;
                dec.src1 = imm;
                rd_used  = 1'b1;
            end
            rv_core_pkg::OP_AUIPC: begin
                dec.cmd  = rv_core_pkg::CMD_ADD;
                dec.src1 = pc;
                dec.src2 = imm;
                rd_used  = 1'b1;
            end
            rv_core_pkg::OP_SYSTEM: begin
                if (inst == `RV_EBREAK) begin
                    dec.cmd = rv_core_pkg::CMD_HALT;
                end
            end
            default: begin
            end
        endcase
        if (!inst_valid) begin
            dec.cmd = rv_core_pkg::CMD_NOP;
        end
        dec.rd = rd_used ? inst[`RV_RD_MSB:`RV_RD_LSB] : '0;
    end

    assign raddr1 = rs1_used ? inst[`RV_RS1_MSB:`RV_RS1_LSB] : '0;
    // No instruction in this subset reads rs2
    assign raddr2 = '0;

endmodule

// ==== logic/rv_regfile.sv ====
`include "rv_core_consts.svh"

module rv_regfile (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`RV_REG_AW-1:0]  waddr,
    input  logic [`RV_XLEN-1:0]    wdata,
    input  logic [`RV_REG_AW-1:0]  raddr1,
    input  logic [`RV_REG_AW-1:0]  raddr2,
    output logic [`RV_XLEN-1:0]    rdata1,
    output logic [`RV_XLEN-1:0]    rdata2
);

    // No storage for x0
    logic [`RV_XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous read ports
    always_comb begin
        rdata1 = '0;
        rdata2 = '0;
        if (raddr1 != '0) begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 != '0) begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// ==== logic/rv_execute.sv ====
`include "rv_core_consts.svh"

module rv_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_valid,
    input  logic [`RV_XLEN-1:0]     pc,
    input  logic [`RV_XLEN-1:0]     inst,
    input  rv_core_pkg::rv_decode_t dec,
    output logic                    we,
    output logic [`RV_REG_AW-1:0]   waddr,
    output logic [`RV_XLEN-1:0]     wdata,
    output logic                    retire_valid,
    output rv_core_pkg::rv_retire_t retire,
    output logic                    halted
);

    logic [`RV_XLEN-1:0] result;

    always_comb begin
        case (dec.cmd)
            rv_core_pkg::CMD_ADD: result = dec.src1 + dec.src2;
            rv_core_pkg::CMD_EQU: result = dec.src1;
            default:              result = '0;
        endcase
    end

    // Write-back in the decode cycle
    assign we    = inst_valid && (dec.cmd == rv_core_pkg::CMD_ADD ||
                                  dec.cmd == rv_core_pkg::CMD_EQU);
    assign waddr = dec.rd;
    assign wdata = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= inst_valid;
            if (inst_valid && dec.cmd == rv_core_pkg::CMD_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    // Retire record
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire <= '{pc: pc, inst: inst, rd: dec.rd, data: result};
        end
    end

endmodule

// ==== logic/rv_core_top.sv ====
`include "rv_core_consts.svh"

module rv_core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic [`RV_WB_AW-1:0]    wb_adr,
    input  logic [`RV_XLEN-1:0]     wb_dat_i,
    input  logic                    wb_ack,
    output logic                    retire_valid,
    output rv_core_pkg::rv_retire_t retire,
    output logic                    halted
);

    logic [`RV_XLEN-1:0]     inst;
    logic [`RV_XLEN-1:0]     pc;
    logic                    inst_valid;
    logic [`RV_REG_AW-1:0]   raddr1;
    logic [`RV_REG_AW-1:0]   raddr2;
    logic [`RV_XLEN-1:0]     rdata1;
    rv_core_pkg::rv_decode_t dec;
    logic                    we;
    logic [`RV_REG_AW-1:0]   waddr;
    logic [`RV_XLEN-1:0]     wdata;

    rv_fetch u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .halted       (halted),
        .retire_valid (retire_valid),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .inst         (inst),
        .pc           (pc),
        .inst_valid   (inst_valid)
    );

    rv_decode u_decode (
        .inst       (inst),
        .pc         (pc),
        .inst_valid (inst_valid),
        .rdata1     (rdata1),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .dec        (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 ()
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .pc           (pc),
        .inst         (inst),
        .dec          (dec),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== dv/rv_core_properties.sv ====
`include "rv_core_consts.svh"

module rv_core_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic [`RV_WB_AW-1:0] wb_adr,
    input logic                 wb_ack,
    input logic                 retire_valid,
    input logic                 halted
);

    timeunit 1ns;
    timeprecision 100ps;

    // ########################################################################
    // Wishbone classic master
    // ########################################################################

    // Request held with cyc and stb together until ack
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n) (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb)
    ) else $error("wb_cyc or wb_stb dropped before wb_ack");

    // Address held while the slave stalls
    adr_stable_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n) (wb_cyc && !wb_ack) |=> $stable(wb_adr)
    ) else $error("wb_adr changed during a wait state");

    // ########################################################################
    // Retire and halt
    // ########################################################################

    retire_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) retire_valid |=> !retire_valid
    ) else $error("retire_valid held for more than one cycle");

    no_bus_after_halt: assert property (
        @(posedge clk) disable iff (!rst_n) halted |-> !wb_cyc
    ) else $error("wb_cyc raised while halted");

endmodule

// ==== dv/rv_core_tb.sv ====
`include "rv_core_consts.svh"

module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_WORDS     = 64;
    localparam int HALT_WATCH     = 20;
    localparam int TIMEOUT_CYCLES = PROG_WORDS * 8 + 40;

    logic                    clk;
    logic                    rst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic [`RV_WB_AW-1:0]    wb_adr;
    logic [`RV_XLEN-1:0]     wb_dat_i;
    logic                    wb_ack;
    logic                    retire_valid;
    rv_core_pkg::rv_retire_t retire;
    logic                    halted;

    logic [`RV_XLEN-1:0]  prog [PROG_WORDS];
    logic [`RV_XLEN-1:0]  model_regs [32];
    logic [31:0]          lcg_state = 32'd6;
    logic [`RV_WB_AW-1:0] expected_adr = `RV_RESET_PC;
    logic                 pending = 1'b0;
    int                   wait_left = 0;
    int                   retired = 0;
    int                   cycles = 0;
    int                   value_errors = 0;
    int                   other_errors = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_core_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

    bind rv_core_top rv_core_properties u_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_ack       (wb_ack),
        .retire_valid (retire_valid),
        .halted       (halted)
    );

    // ########################################################################
    // Random program
    // ########################################################################

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic build_program();
        logic [31:0] word;
        logic [7:0]  written;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [2:0]  kind;
        // Only x0..x7 so registers get reused
        // Unwritten registers are never read
        written = 8'h01;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            kind = 3'(lcg_next() % 5);
            rd   = 5'(lcg_next() % 8);
            rs1  = 5'(lcg_next() % 8);
            if (!written[rs1[2:0]]) begin
                rs1 = 5'd0;
            end
            word = {lcg_next(), lcg_next()};
            case (kind)
                3'd0: word = {word[31:20], rs1, 3'b000, rd, 7'b0010011};
                3'd1: word = {word[31:12], rd, 7'b0110111};
                3'd2: word = {word[31:12], rd, 7'b0010111};
                3'd3: word = {word[31:20], rs1, 3'(1 + lcg_next() % 7), rd, 7'b0010011};
                default: word = {word[31:7], word[0] ? 7'b0110011 : 7'b1100011};
            endcase
            if (kind < 3'd3) begin
                written[rd[2:0]] = 1'b1;
            end
            prog[i] = word;
        end
        prog[PROG_WORDS-1] = `RV_EBREAK;
    endtask

    // Expected retire record and model register update
    function automatic rv_core_pkg::rv_retire_t expected_retire(
        input logic [31:0] inst,
        input logic [31:0] pc,
        ref   logic [31:0] regs [32]
    );
        rv_core_pkg::rv_retire_t want;
        logic [31:0]             imm_i;
        logic [31:0]             imm_u;
        imm_i     = {{20{inst[31]}}, inst[31:20]};
        imm_u     = {inst[31:12], 12'h000};
        want.pc   = pc;
        want.inst = inst;
        want.rd   = 5'd0;
        want.data = 32'd0;
        if (inst[6:0] == 7'b0010011 && inst[14:12] == 3'b000) begin
            want.rd   = inst[11:7];
            want.data = regs[inst[19:15]] + imm_i;
        end else if (inst[6:0] == 7'b0110111) begin
            want.rd   = inst[11:7];
            want.data = imm_u;
        end else if (inst[6:0] == 7'b0010111) begin
            want.rd   = inst[11:7];
            want.data = pc + imm_u;
        end
        if (want.rd != 5'd0) begin
            regs[want.rd] = want.data;
        end
        return want;
    endfunction

    task automatic finish_run();
        $display("Retired %0d of %0d, value errors %0d, other errors %0d",
                 retired, PROG_WORDS, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // ########################################################################
    // Wishbone memory slave
    // ########################################################################

    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            wb_ack  = 1'b0;
            pending = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = lcg_next() % 4;
                if (wb_adr != expected_adr) begin
                    value_errors++;
                    $display("FAILED wb_adr expected %h got %h", expected_adr, wb_adr);
                end
                if (wb_adr[31:2] >= PROG_WORDS) begin
                    other_errors++;
                    $display("Fetch from an address outside the program");
                end
                expected_adr = expected_adr + 32'd4;
            end
            if (wait_left == 0) begin
                wb_dat_i = prog[wb_adr[7:2]];
                wb_ack   = 1'b1;
                pending  = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // ########################################################################
    // Compare and timeout
    // ########################################################################

    always @(posedge clk) begin
        rv_core_pkg::rv_retire_t want;
        if (rst_n && retire_valid) begin
            if (retired >= PROG_WORDS) begin
                other_errors++;
                $display("An instruction retired after the core halted");
            end else begin
                want = expected_retire(prog[retired], `RV_RESET_PC + 32'(retired * 4),
                                       model_regs);
                if (retire.pc != want.pc) begin
                    value_errors++;
                    $display("FAILED retire.pc expected %h got %h", want.pc, retire.pc);
                end
                if (retire.inst != want.inst) begin
                    value_errors++;
                    $display("FAILED retire.inst expected %h got %h", want.inst, retire.inst);
                end
                if (retire.rd != want.rd) begin
                    value_errors++;
                    $display("FAILED retire.rd expected %h got %h", want.rd, retire.rd);
                end
                if (retire.data != want.data) begin
                    value_errors++;
                    $display("FAILED retire.data expected %h got %h", want.data, retire.data);
                end
                if (retired == PROG_WORDS - 1 && !halted) begin
                    other_errors++;
                    $display("Core did not halt when ebreak retired");
                end
            end
            retired++;
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        other_errors++;
        $display("Timeout: core did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run();
    end

    initial begin
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        wait (rst_n);
        wait (halted);
        // Bus must stay quiet once halted
        repeat (HALT_WATCH) begin
            @(posedge clk);
            if (wb_cyc) begin
                other_errors++;
                $display("Bus cycle started after the core halted");
            end
        end
        if (retired != PROG_WORDS) begin
            other_errors++;
            $display("Wrong number of retired instructions: %0d", retired);
        end
        finish_run();
    end

endmodule

// ==== tb.f ====
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_core_top.sv
dv/tb_clock_gen.sv
dv/rv_core_properties.sv
dv/rv_core_tb.sv
